/* logic/trace_view_pkg.sv */
package trace_view_pkg;

    typedef logic [63:0] word_t;
    typedef logic [7:0]  char_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [9:0]  cell_addr_t;
    typedef logic [2:0]  field_idx_t; // pc, inst, rs1, rs2, alu, mem_addr, rd, npc
    typedef logic [7:0]  seg_t;       // active low, bit 7 is the dot
    typedef logic [7:0]  digit_en_t;  // active low

    localparam int FIELD_COUNT      = 8;
    localparam int DIGITS_PER_FIELD = 16;
    localparam int TEXT_COLS        = 80;
    localparam int TEXT_CELLS       = 640; // 8 lines of 80
    localparam int CELLS_PER_SWEEP  = FIELD_COUNT * DIGITS_PER_FIELD;

    // sweep position splits into field and digit
    localparam int DIGIT_W = $clog2(DIGITS_PER_FIELD);
    localparam int SWEEP_W = $clog2(CELLS_PER_SWEEP);

    typedef enum logic {
        WAIT_FIRST, // nothing captured yet
        SWEEP
    } writer_state_t;

endpackage

/* logic/char_cell_if.sv */
`timescale 1ns/1ps

interface char_cell_if
    import trace_view_pkg::*;
();

    logic       valid;
    cell_addr_t addr;
    char_t      ch;
    logic       credit; // one pulse per cell leaving the receiver

    modport sender (
        output valid,
        output addr,
        output ch,
        input  credit
    );

    modport receiver (
        input  valid,
        input  addr,
        input  ch,
        output credit
    );

endinterface

/* logic/trace_text_writer.sv */
`timescale 1ns/1ps

module trace_text_writer
    import trace_view_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trace_valid,
    input  word_t [FIELD_COUNT-1:0]       trace_fields,
    output word_t [FIELD_COUNT-1:0]       snapshot,
    char_cell_if.sender                   cells
);

    localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

    writer_state_t        state;
    logic [SWEEP_W-1:0]   pos;
    logic [CRED_W-1:0]    credit_cnt;
    field_idx_t           field;
    logic [DIGIT_W-1:0]   digit;
    logic [DIGIT_W-1:0]   rev;
    nibble_t              nib;
    logic                 send;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snapshot <= '0;
        end else if (trace_valid) begin
            snapshot <= trace_fields;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT_FIRST;
        end else if (state == WAIT_FIRST && trace_valid) begin
            state <= SWEEP; // never leaves, sweeps repeat
        end
    end

    assign send = (state == SWEEP) && (credit_cnt != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= '0;
        end else if (send) begin
            pos <= pos + 1'b1; // wraps after the last npc digit
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= CRED_W'(FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - CRED_W'(send) + CRED_W'(cells.credit);
        end
    end

    assign field = field_idx_t'(pos >> DIGIT_W);
    assign digit = pos[DIGIT_W-1:0];
    assign rev   = DIGIT_W'(DIGITS_PER_FIELD - 1) - digit; // digit 0 is the top nibble
    assign nib   = snapshot[field][rev*4 +: 4];

    assign cells.valid = send;
    assign cells.ch    = (nib < 4'd10) ? char_t'(8'd48 + nib) : char_t'(8'd87 + nib);
    // blank cell after every group of four digits
    assign cells.addr  = cell_addr_t'(field) * cell_addr_t'(TEXT_COLS)
                       + cell_addr_t'(digit) + cell_addr_t'(digit >> 2);

    // no credit can return while every credit is home
    a_no_spurious_credit: assert property (
        @(posedge clk) disable iff (rst) cells.credit |-> credit_cnt != CRED_W'(FIFO_DEPTH)
    );

    // credits come back only for cells the FIFO really popped
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst) credit_cnt <= CRED_W'(FIFO_DEPTH)
    );

endmodule

/* logic/char_cell_fifo.sv */
`timescale 1ns/1ps

module char_cell_fifo
    import trace_view_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst,
    char_cell_if.receiver in_cells,
    char_cell_if.sender   out_cells
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cell_addr_t         addr_mem [FIFO_DEPTH];
    char_t              ch_mem   [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               dn_credit; // single slot in the vram hold register
    logic               pop;

    // a credit returned this cycle can be spent right away
    assign pop = (count != '0) && (dn_credit || out_cells.credit);

    always_ff @(posedge clk) begin
        if (in_cells.valid) begin
            addr_mem[wr_ptr] <= in_cells.addr;
            ch_mem[wr_ptr]   <= in_cells.ch;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            dn_credit <= 1'b1;
        end else begin
            if (in_cells.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(in_cells.valid) - CNT_W'(pop);
            dn_credit <= dn_credit + out_cells.credit - pop;
        end
    end

    assign out_cells.valid = pop;
    assign out_cells.addr  = addr_mem[rd_ptr];
    assign out_cells.ch    = ch_mem[rd_ptr];
    assign in_cells.credit = pop; // upstream credit in the pop cycle

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) in_cells.valid |-> count < CNT_W'(FIFO_DEPTH)
    );

endmodule

/* logic/text_vram.sv */
`timescale 1ns/1ps

module text_vram
    import trace_view_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    char_cell_if.receiver cells,
    input  logic          rd_en,
    input  cell_addr_t    rd_addr,
    output char_t         rd_data
);

    char_t      mem [TEXT_CELLS];
    logic       hold_valid;
    cell_addr_t hold_addr;
    char_t      hold_ch;
    logic       wr_en;

    initial begin
        for (int i = 0; i < TEXT_CELLS; i++) begin
            mem[i] = '0; // blank screen at power up
        end
    end

    assign wr_en = hold_valid && !rd_en; // host read wins the port

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (cells.valid) begin
            hold_valid <= 1'b1;
        end else if (wr_en) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cells.valid) begin
            hold_addr <= cells.addr;
            hold_ch   <= cells.ch;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end else if (wr_en) begin
            mem[hold_addr] <= hold_ch;
        end
    end

    assign cells.credit = wr_en;

    // a blocked cell survives the read cycle untouched
    a_read_blocks_write: assert property (
        @(posedge clk) disable iff (rst)
        (hold_valid && rd_en) |=> hold_valid && hold_addr == $past(hold_addr)
    );

endmodule

/* logic/seg_scan.sv */
`timescale 1ns/1ps

module seg_scan
    import trace_view_pkg::*;
#(
    parameter int SCAN_DIV = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] value,
    output seg_t        seg,
    output digit_en_t   an
);

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       digit; // active digit, 0 is the rightmost
    nibble_t          nib;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            digit   <= '0;
        end else if (div_cnt == DIV_W'(SCAN_DIV - 1)) begin
            div_cnt <= '0;
            digit   <= digit + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign an  = ~(digit_en_t'(1) << digit);
    assign nib = value[digit*4 +: 4];

    always_comb begin
        case (nib)
            4'h0: seg = 8'b1100_0000;
            4'h1: seg = 8'b1111_1001;
            4'h2: seg = 8'b1010_0100;
            4'h3: seg = 8'b1011_0000;
            4'h4: seg = 8'b1001_1001;
            4'h5: seg = 8'b1001_0010;
            4'h6: seg = 8'b1000_0010;
            4'h7: seg = 8'b1111_1000;
            4'h8: seg = 8'b1000_0000;
            4'h9: seg = 8'b1001_0000;
            4'ha: seg = 8'b1000_1000;
            4'hb: seg = 8'b1000_0011;
            4'hc: seg = 8'b1100_0110;
            4'hd: seg = 8'b1010_0001;
            4'he: seg = 8'b1000_0110;
            default: seg = 8'b1000_1110; // f
        endcase
    end

endmodule

/* logic/trace_view_top.sv */
`timescale 1ns/1ps

module trace_view_top
    import trace_view_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int SCAN_DIV   = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       trace_valid,
    input  word_t      trace_pc,
    input  word_t      trace_inst,
    input  word_t      trace_rs1,
    input  word_t      trace_rs2,
    input  word_t      trace_alu,
    input  word_t      trace_mem_addr,
    input  word_t      trace_rd,
    input  word_t      trace_npc,
    input  field_idx_t disp_sel,
    input  logic       disp_upper,
    input  logic       rd_en,
    input  cell_addr_t rd_addr,
    output char_t      rd_data,
    output seg_t       seg,
    output digit_en_t  an
);

    word_t [FIELD_COUNT-1:0] trace_fields;
    word_t [FIELD_COUNT-1:0] snapshot;
    word_t                   sel_word;
    logic [31:0]             disp_value;

    char_cell_if wr_cells ();
    char_cell_if mem_cells ();

    // index order matches field_idx_t
    assign trace_fields = {trace_npc, trace_rd, trace_mem_addr, trace_alu,
                           trace_rs2, trace_rs1, trace_inst, trace_pc};

    trace_text_writer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_writer (
        .clk          (clk),
        .rst          (rst),
        .trace_valid  (trace_valid),
        .trace_fields (trace_fields),
        .snapshot     (snapshot),
        .cells        (wr_cells.sender)
    );

    char_cell_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_cells  (wr_cells.receiver),
        .out_cells (mem_cells.sender)
    );

    text_vram u_vram (
        .clk     (clk),
        .rst     (rst),
        .cells   (mem_cells.receiver),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    assign sel_word   = snapshot[disp_sel];
    assign disp_value = disp_upper ? sel_word[63:32] : sel_word[31:0];

    seg_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_seg (
        .clk   (clk),
        .rst   (rst),
        .value (disp_value),
        .seg   (seg),
        .an    (an)
    );

endmodule

/* bench/trace_view_checker.sv */
`timescale 1ns/1ps

module trace_view_checker
    import trace_view_pkg::*;
#(
    parameter int SCAN_DIV = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  int                      test_id,
    input  logic                    check_reads,
    input  logic                    run_done,
    input  logic                    trace_valid,
    input  word_t [FIELD_COUNT-1:0] fields,
    input  field_idx_t              disp_sel,
    input  logic                    disp_upper,
    input  logic                    rd_en,
    input  cell_addr_t              rd_addr,
    input  char_t                   rd_data,
    input  seg_t                    seg,
    input  digit_en_t               an,
    output int                      total_errors,
    output logic                    report_done
);

    // active low gfedcba, dot off
    localparam seg_t SEG_TABLE [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    word_t [FIELD_COUNT-1:0] model;
    char_t                   exp_screen [TEXT_CELLS];
    logic                    first_sample;
    int                      prev_digit;
    int                      dwell; // samples spent on the current digit
    logic                    pend_valid;
    cell_addr_t              pend_addr;
    int                      cur_test;
    int                      test_checks;
    int                      test_errors;
    int                      total_checks;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset state";
            2: return "capture and seven-segment";
            3: return "scan order";
            4: return "text rendering";
            5: return "back-pressure";
            default: return "unknown";
        endcase
    endfunction

    function automatic char_t hex_char(input nibble_t n);
        return (n < 4'd10) ? char_t'(8'd48 + n) : char_t'(8'd97 + n - 8'd10);
    endfunction

    // expected screen, built forward from the layout rule
    task automatic render_model();
        int      addr;
        nibble_t nib;
        for (int i = 0; i < TEXT_CELLS; i++) begin
            exp_screen[i] = '0;
        end
        for (int f = 0; f < FIELD_COUNT; f++) begin
            for (int d = 0; d < DIGITS_PER_FIELD; d++) begin
                addr = f * TEXT_COLS + d + d / 4;
                nib  = model[f][(DIGITS_PER_FIELD - 1 - d) * 4 +: 4]; // d = 0 is the top nibble
                exp_screen[addr] = hex_char(nib);
            end
        end
    endtask

    task automatic compare8(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("Mismatch at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        test_errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic check_display();
        int          low_bits;
        int          k;
        logic [31:0] half;
        low_bits = 0;
        k        = 0;
        for (int i = 0; i < 8; i++) begin
            if (!an[i]) begin
                low_bits++;
                k = i;
            end
        end
        test_checks++;
        if (low_bits != 1) begin
            report_failure($sformatf("an = %b does not select exactly one digit", an));
        end else begin
            if (first_sample) begin
                compare8("an", 8'hfe, an); // digit 0 right after reset
                dwell = 1;
            end else if (k == prev_digit) begin
                dwell++;
                if (dwell == SCAN_DIV + 1) begin
                    report_failure($sformatf("scan stuck on digit %0d", k));
                end
            end else if (k == (prev_digit + 1) % 8) begin
                if (dwell != SCAN_DIV) begin
                    report_failure($sformatf("digit %0d held for %0d cycles instead of %0d",
                                             prev_digit, dwell, SCAN_DIV));
                end
                dwell = 1;
            end else begin
                report_failure($sformatf("scan moved from digit %0d to %0d", prev_digit, k));
                dwell = 1;
            end
            half = disp_upper ? model[disp_sel][63:32] : model[disp_sel][31:0];
            compare8("seg", SEG_TABLE[half[k*4 +: 4]], seg);
            prev_digit = k;
        end
        first_sample = 1'b0;
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            $display("test %0d (%s): %0d checks, %0d errors",
                     cur_test, test_name(cur_test), test_checks, test_errors);
            total_checks += test_checks;
            total_errors += test_errors;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        model = '0;
        for (int i = 0; i < TEXT_CELLS; i++) begin
            exp_screen[i] = '0; // nothing rendered yet
        end
        first_sample = 1'b1;
        prev_digit   = 0;
        dwell        = 0;
        pend_valid   = 1'b0;
        pend_addr    = '0;
        cur_test     = 0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        report_done  = 1'b0;
    end

    // sampled on the rising edge, half a cycle after the bench drives
    always @(posedge clk) begin
        if (rst) begin
            first_sample = 1'b1;
            prev_digit   = 0;
            pend_valid   = 1'b0;
        end else begin
            if (pend_valid) begin
                compare8($sformatf("rd_data[%0d]", pend_addr), exp_screen[pend_addr], rd_data);
            end
            check_display();
            pend_valid = check_reads && rd_en; // data shows up one cycle later
            pend_addr  = rd_addr;
            if (trace_valid) begin
                model = fields;
                render_model();
            end
        end
        if (test_id != cur_test) begin
            close_test();
            cur_test = test_id;
        end
        if (run_done && !report_done) begin
            close_test();
            $display("total: %0d checks, %0d errors", total_checks, total_errors);
            report_done = 1'b1;
        end
    end

endmodule

/* bench/trace_view_tb.sv */
`timescale 1ns/1ps

module trace_view_tb
    import trace_view_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 3;
    localparam int SCAN_DIV       = 4;
    localparam int SETTLE_CYCLES  = 2 * CELLS_PER_SWEEP + 16;
    localparam int READ_CYCLES    = TEXT_CELLS + 2;
    localparam int CAPTURE_CYCLES = 400;
    localparam int SCAN_CYCLES    = 96;
    localparam int BUSY_CYCLES    = 600;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + 3 * READ_CYCLES + CAPTURE_CYCLES
                                  + SCAN_CYCLES + 2 * (SETTLE_CYCLES + 2) + BUSY_CYCLES + 8;
    localparam int WATCHDOG_NS    = TOTAL_CYCLES * CLK_PERIOD * 2;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    trace_valid;
    word_t [FIELD_COUNT-1:0] fields; // pc, inst, rs1, rs2, alu, mem_addr, rd, npc
    field_idx_t              disp_sel;
    logic                    disp_upper;
    logic                    rd_en;
    cell_addr_t              rd_addr;
    char_t                   rd_data;
    seg_t                    seg;
    digit_en_t               an;
    int                      test_id;
    logic                    check_reads;
    logic                    run_done;
    int                      total_errors;
    logic                    report_done;

    always #(CLK_PERIOD / 2) clk = ~clk;

    trace_view_top #(
        .FIFO_DEPTH (4),
        .SCAN_DIV   (SCAN_DIV)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .trace_valid    (trace_valid),
        .trace_pc       (fields[0]),
        .trace_inst     (fields[1]),
        .trace_rs1      (fields[2]),
        .trace_rs2      (fields[3]),
        .trace_alu      (fields[4]),
        .trace_mem_addr (fields[5]),
        .trace_rd       (fields[6]),
        .trace_npc      (fields[7]),
        .disp_sel       (disp_sel),
        .disp_upper     (disp_upper),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .seg            (seg),
        .an             (an)
    );

    trace_view_checker #(
        .SCAN_DIV (SCAN_DIV)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .test_id      (test_id),
        .check_reads  (check_reads),
        .run_done     (run_done),
        .trace_valid  (trace_valid),
        .fields       (fields),
        .disp_sel     (disp_sel),
        .disp_upper   (disp_upper),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .seg          (seg),
        .an           (an),
        .total_errors (total_errors),
        .report_done  (report_done)
    );

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            trace_valid = 1'b0;
            rd_en       = 1'b0;
        end
    endtask

    task automatic load_random_record();
        for (int f = 0; f < FIELD_COUNT; f++) begin
            fields[f] = {$urandom, $urandom};
        end
    endtask

    task automatic random_display_select();
        disp_sel   = field_idx_t'($urandom % FIELD_COUNT);
        disp_upper = 1'($urandom % 2);
    endtask

    task automatic capture_once();
        @(negedge clk);
        load_random_record();
        trace_valid = 1'b1;
        @(negedge clk);
        trace_valid = 1'b0;
    endtask

    // whole screen, one read per cycle
    task automatic read_screen();
        for (int a = 0; a < TEXT_CELLS; a++) begin
            @(negedge clk);
            rd_en   = 1'b1;
            rd_addr = cell_addr_t'(a);
        end
        idle(2);
    endtask

    initial begin
        void'($urandom(32'ha4fe));
        rst         = 1'b1;
        trace_valid = 1'b0;
        fields      = '0;
        disp_sel    = '0;
        disp_upper  = 1'b0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        test_id     = 1;
        check_reads = 1'b1;
        run_done    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        read_screen(); // blank screen before any capture

        test_id = 2;
        repeat (CAPTURE_CYCLES) begin
            @(negedge clk);
            load_random_record();
            trace_valid = ($urandom % 4 == 0);
            random_display_select();
        end

        test_id = 3;
        repeat (SCAN_CYCLES) begin
            @(negedge clk);
            trace_valid = 1'b0;
            if ($urandom % 8 == 0) begin
                random_display_select();
            end
        end

        test_id = 4;
        capture_once();
        idle(SETTLE_CYCLES);
        read_screen();

        test_id     = 5;
        check_reads = 1'b0; // screen is half old, half new meanwhile
        for (int i = 0; i < BUSY_CYCLES; i++) begin
            @(negedge clk);
            if (i == 0) begin
                load_random_record();
            end
            trace_valid = (i == 0);
            rd_en       = ($urandom % 10 < 7);
            rd_addr     = cell_addr_t'($urandom % TEXT_CELLS);
        end
        idle(1);
        check_reads = 1'b1;
        idle(SETTLE_CYCLES);
        read_screen();

        run_done = 1'b1;
        wait (report_done);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* trace_view_top.f */
logic/trace_view_pkg.sv
logic/char_cell_if.sv
logic/trace_text_writer.sv
logic/char_cell_fifo.sv
logic/text_vram.sv
logic/seg_scan.sv
logic/trace_view_top.sv
bench/trace_view_checker.sv
bench/trace_view_tb.sv

/* Bender.yml */
package:
  name: trace_view

sources:
  - files:
      - logic/trace_view_pkg.sv
      - logic/char_cell_if.sv
      - logic/trace_text_writer.sv
      - logic/char_cell_fifo.sv
      - logic/text_vram.sv
      - logic/seg_scan.sv
      - logic/trace_view_top.sv
  - target: test
    files:
      - bench/trace_view_checker.sv
      - bench/trace_view_tb.sv
